// File: dbg_stall_ctrl.f
+incdir+design
design/dbg_pkg.sv
design/dbg_cmd_decode.sv
design/dbg_stall_cell.sv
design/dbg_status_collect.sv
design/dbg_stall_ctrl.sv
bench/dbg_stall_ctrl_props.sv
bench/tb_dbg_stall_ctrl.sv

// File: bench/tb_dbg_stall_ctrl.sv
// Testbench for the debug stall controller
// Drives random host commands and breakpoint pulses, lets the clock
// crossings settle and compares readback and core stalls with a mask model

`timescale 1ns/1ps

`include "dbg_stall_config.svh"

module tb_dbg_stall_ctrl
  import dbg_pkg::*;
();

  // TCK edges without an output change that count as settled
  localparam int QUIET_TCK     = 10;
  localparam int QUIET_TIMEOUT = 200;
  localparam int MIX_STEPS     = 200;

  logic         tck_i;
  logic         tlr_i;
  logic         cpu_clk_i;
  logic         cpu_rstn_i;
  dbg_cmd_e     host_cmd_i;
  core_mask_t   host_mask_i;
  status_word_t host_status_o;
  core_mask_t   bp_i;
  core_mask_t   cpu_stall_o;

  // Expected host stall register and sticky breakpoint flags
  core_mask_t   model_stall;
  core_mask_t   model_bp_seen;

  integer seed          = 32'h1ec8;
  int     check_count   = 0;
  int     error_count   = 0;
  int     timeout_count = 0;

  dbg_stall_ctrl u_dbg_stall_ctrl (
    .tck_i         (tck_i),
    .tlr_i         (tlr_i),
    .cpu_clk_i     (cpu_clk_i),
    .cpu_rstn_i    (cpu_rstn_i),
    .host_cmd_i    (host_cmd_i),
    .host_mask_i   (host_mask_i),
    .host_status_o (host_status_o),
    .bp_i          (bp_i),
    .cpu_stall_o   (cpu_stall_o)
  );

  ////////////////////////////////////////////////////////////////////
  // Clocks
  ////////////////////////////////////////////////////////////////////

  // CPU at 8 ns, TCK at 40 ns, TCK edges fall on CPU edges of the same kind
  initial begin
    cpu_clk_i = 1'b0;
    forever begin
      #4 cpu_clk_i = ~cpu_clk_i;
    end
  end

  initial begin
    tck_i = 1'b0;
    forever begin
      #20 tck_i = ~tck_i;
    end
  end

  // A raised breakpoint already stalls its core, checked mid-cycle while the pulse is held
  always @(negedge cpu_clk_i) begin
    assert ((cpu_stall_o & bp_i) == bp_i) else begin
      error_count++;
      $display("[ERROR] cpu_stall_o got 0x%h with bp_i 0x%h", cpu_stall_o, bp_i);
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////

  function automatic core_mask_t random_mask();
    return core_mask_t'($random(seed));
  endfunction

  // Closing line and verdict
  task automatic finish_run();
    $display("Checks %0d, errors %0d, timeouts %0d",
             check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  // Holds the command for one TCK cycle and then returns to idle
  task automatic issue_cmd(input dbg_cmd_e cmd, input core_mask_t mask);
    @(posedge tck_i);
    host_cmd_i  <= cmd;
    host_mask_i <= mask;
    @(posedge tck_i);
    host_cmd_i  <= CMD_NOP;
    host_mask_i <= '0;
  endtask

  // One CPU cycle breakpoint on every core in the mask
  task automatic pulse_bp(input core_mask_t mask);
    @(posedge cpu_clk_i);
    bp_i <= mask;
    @(posedge cpu_clk_i);
    bp_i <= '0;
  endtask

  // Waits until neither output has moved for QUIET_TCK edges
  task automatic wait_quiet();
    status_word_t last_status;
    core_mask_t   last_stall;
    int           quiet;
    int           edges;
    last_status = host_status_o;
    last_stall  = cpu_stall_o;
    quiet       = 0;
    edges       = 0;
    while (quiet < QUIET_TCK && edges < QUIET_TIMEOUT) begin
      @(negedge tck_i);
      edges++;
      if (host_status_o != last_status || cpu_stall_o != last_stall) begin
        last_status = host_status_o;
        last_stall  = cpu_stall_o;
        quiet       = 0;
      end else begin
        quiet++;
      end
    end
    if (quiet < QUIET_TCK) begin
      timeout_count++;
      $display("Timeout: DUT outputs still moving after %0d TCK cycles", edges);
    end
  endtask

  // Compares readback and core stalls with the model
  task automatic check_state(input int step);
    check_count++;
    assert (host_status_o.stalled == model_stall) else begin
      error_count++;
      $display("[ERROR] step %0d host_status_o.stalled got 0x%h expected 0x%h",
               step, host_status_o.stalled, model_stall);
    end
    assert (host_status_o.bp_seen == model_bp_seen) else begin
      error_count++;
      $display("[ERROR] step %0d host_status_o.bp_seen got 0x%h expected 0x%h",
               step, host_status_o.bp_seen, model_bp_seen);
    end
    assert (cpu_stall_o == model_stall) else begin
      error_count++;
      $display("[ERROR] step %0d cpu_stall_o got 0x%h expected 0x%h",
               step, cpu_stall_o, model_stall);
    end
  endtask

  // A settled breakpoint leaves the host register set and the flag up
  task automatic bp_step(input int step, input core_mask_t mask);
    pulse_bp(mask);
    wait_quiet();
    model_stall   = model_stall | mask;
    model_bp_seen = model_bp_seen | mask;
    check_state(step);
  endtask

  // Any write of 0 to a core also drops its sticky flag
  task automatic cmd_step(input int step, input dbg_cmd_e cmd, input core_mask_t mask);
    issue_cmd(cmd, mask);
    wait_quiet();
    case (cmd)
      CMD_WRITE: begin
        model_stall   = mask;
        model_bp_seen = model_bp_seen & mask;
      end
      CMD_HALT: begin
        model_stall = model_stall | mask;
      end
      CMD_RESUME: begin
        model_stall   = model_stall & ~mask;
        model_bp_seen = model_bp_seen & ~mask;
      end
    endcase
    check_state(step);
  endtask

  ////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////

  initial begin
    int         sel;
    core_mask_t pick;
    tlr_i         = 1'b1;
    cpu_rstn_i    = 1'b0;
    host_cmd_i    = CMD_NOP;
    host_mask_i   = '0;
    bp_i          = '0;
    model_stall   = '0;
    model_bp_seen = '0;

    // Each reset is held for two cycles of its own clock
    fork
      begin
        for (int i = 0; i < 2; i++) @(posedge cpu_clk_i);
        cpu_rstn_i <= 1'b1;
      end
      begin
        for (int i = 0; i < 2; i++) @(posedge tck_i);
        tlr_i <= 1'b0;
      end
    join
    wait_quiet();
    check_state(0);

    // Single-core breakpoints stick until the host acts
    for (int n = 1; n <= 4 && timeout_count == 0; n++) begin
      pick = core_mask_t'(1) << ($unsigned($random(seed)) % `DBG_NUM_CORES);
      bp_step(n, pick);
    end

    // Full writes set an exact pattern
    for (int n = 5; n <= 8 && timeout_count == 0; n++) begin
      cmd_step(n, CMD_WRITE, random_mask());
    end

    // Halt and resume touch only the masked cores
    for (int n = 9; n <= 16 && timeout_count == 0; n++) begin
      if (n % 2 == 1) begin
        cmd_step(n, CMD_HALT, random_mask());
      end else begin
        cmd_step(n, CMD_RESUME, random_mask());
      end
    end

    // Random mix, selector 0 is a breakpoint and the rest map to commands
    for (int n = 17; n < 17 + MIX_STEPS && timeout_count == 0; n++) begin
      sel = $unsigned($random(seed)) % 4;
      if (sel == 0) begin
        bp_step(n, random_mask());
      end else begin
        cmd_step(n, dbg_cmd_e'(sel[1:0]), random_mask());
      end
    end

    finish_run();
  end

endmodule

// File: bench/dbg_stall_ctrl_props.sv
// Debug stall controller assertions
// Bound into the top level, covers the same-cycle breakpoint stall,
// the readback to CPU stall relation and the state right after reset

`timescale 1ns/1ps

`include "dbg_stall_config.svh"

module dbg_stall_ctrl_props
  import dbg_pkg::*;
(
  input logic         tck_i,
  input logic         tlr_i,
  input logic         cpu_clk_i,
  input logic         cpu_rstn_i,
  input status_word_t host_status_o,
  input core_mask_t   bp_i,
  input core_mask_t   cpu_stall_o
);

  // CPU cycles a new readback stall may take to show on the core
  localparam int STALL_SETTLE = 6;

  ////////////////////////////////////////////////////////////////////
  // Breakpoint stall
  ////////////////////////////////////////////////////////////////////

  // A raised breakpoint never leaves its core running, not even for a cycle
  bp_stalls_now: assert property (
    @(posedge cpu_clk_i) disable iff (tlr_i)
    (bp_i & ~cpu_stall_o) == '0
  ) else $error("Breakpoint raised on a core that is not stalled");

  ////////////////////////////////////////////////////////////////////
  // Readback against the core
  ////////////////////////////////////////////////////////////////////

  // The readback lags the host register by a TCK cycle, so by the time a
  // stalled bit rises the core is already held or about to be
  for (genvar i = 0; i < `DBG_NUM_CORES; i++) begin : g_core
    stall_reaches_core: assert property (
      @(posedge cpu_clk_i) disable iff (tlr_i || !cpu_rstn_i)
      $rose(host_status_o.stalled[i]) |-> ##[0:STALL_SETTLE] cpu_stall_o[i]
    ) else $error("Readback shows core %0d stalled but the core never stalls", i);
  end

  ////////////////////////////////////////////////////////////////////
  // Reset values
  ////////////////////////////////////////////////////////////////////

  cpu_reset_clear: assert property (
    @(posedge cpu_clk_i) $rose(cpu_rstn_i) |-> (cpu_stall_o & ~bp_i) == '0
  ) else $error("Core stall left set after CPU reset");

  tck_reset_clear: assert property (
    @(posedge tck_i) $fell(tlr_i) |-> host_status_o == '0
  ) else $error("Readback word not cleared after test-logic reset");

endmodule

// Attach the checks to every instance of the controller
bind dbg_stall_ctrl dbg_stall_ctrl_props u_props (
  .tck_i         (tck_i),
  .tlr_i         (tlr_i),
  .cpu_clk_i     (cpu_clk_i),
  .cpu_rstn_i    (cpu_rstn_i),
  .host_status_o (host_status_o),
  .bp_i          (bp_i),
  .cpu_stall_o   (cpu_stall_o)
);

// File: design/dbg_stall_ctrl.sv
// Debug stall controller top level
// Host command decoder, one stall cell per core and the readback collector.
// The host side runs on TCK, the stall outputs on the CPU clock

`timescale 1ns/1ps

`include "dbg_stall_config.svh"

module dbg_stall_ctrl
  import dbg_pkg::*;
(
  // JTAG side, test-logic reset is active high
  input  logic         tck_i,
  input  logic         tlr_i,

  // CPU side, reset is active low
  input  logic         cpu_clk_i,
  input  logic         cpu_rstn_i,

  // Host command port, one command per TCK edge
  input  dbg_cmd_e     host_cmd_i,
  input  core_mask_t   host_mask_i,
  output status_word_t host_status_o,

  // Breakpoints in and stalls out, one bit per core
  input  core_mask_t   bp_i,
  output core_mask_t   cpu_stall_o
);

  ////////////////////////////////////////////////////////////////////
  // Internal wiring
  ////////////////////////////////////////////////////////////////////

  // Registered write requests from the decoder, one per core
  stall_wr_t    [`DBG_NUM_CORES-1:0] wr_req;

  // TCK-domain status from every cell
  core_status_t [`DBG_NUM_CORES-1:0] core_status;

  ////////////////////////////////////////////////////////////////////
  // Command decoder
  ////////////////////////////////////////////////////////////////////

  dbg_cmd_decode u_cmd_decode (
    .tck_i       (tck_i),
    .tlr_i       (tlr_i),
    .host_cmd_i  (host_cmd_i),
    .host_mask_i (host_mask_i),
    .wr_req_o    (wr_req)
  );

  ////////////////////////////////////////////////////////////////////
  // Stall cells
  ////////////////////////////////////////////////////////////////////

  // Each core gets its own copy, indexed by the flat core number
  for (genvar i = 0; i < `DBG_NUM_CORES; i++) begin : g_core
    dbg_stall_cell u_stall_cell (
      .tck_i       (tck_i),
      .tlr_i       (tlr_i),
      .cpu_clk_i   (cpu_clk_i),
      .cpu_rstn_i  (cpu_rstn_i),
      .wr_req_i    (wr_req[i]),
      .bp_i        (bp_i[i]),
      .cpu_stall_o (cpu_stall_o[i]),
      .status_o    (core_status[i])
    );
  end

  ////////////////////////////////////////////////////////////////////
  // Readback
  ////////////////////////////////////////////////////////////////////

  // The collector also watches the requests to clear sticky flags
  dbg_status_collect u_status_collect (
    .tck_i         (tck_i),
    .tlr_i         (tlr_i),
    .status_i      (core_status),
    .wr_req_i      (wr_req),
    .host_status_o (host_status_o)
  );

endmodule

// File: design/dbg_status_collect.sv
// Readback collector
// Gathers every cell's status in the TCK domain, keeps a sticky breakpoint
// flag per core and registers the host readback word

`timescale 1ns/1ps

`include "dbg_stall_config.svh"

module dbg_status_collect
  import dbg_pkg::*;
(
  input  logic                                tck_i,
  input  logic                                tlr_i,
  input  core_status_t [`DBG_NUM_CORES-1:0]   status_i,
  input  stall_wr_t    [`DBG_NUM_CORES-1:0]   wr_req_i,
  output status_word_t                        host_status_o
);

  // Per-core views of the cell status and the pending write requests
  core_mask_t stalled_mask;
  core_mask_t bp_set;
  core_mask_t bp_clr;

  // Sticky record of a breakpoint stop on each core
  core_mask_t bp_seen;

  ////////////////////////////////////////////////////////////////////
  // Flatten the per-core records
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < `DBG_NUM_CORES; i++) begin
      stalled_mask[i] = status_i[i].stalled;
      bp_set[i]       = status_i[i].bp_tck;
      // Only a write of 0 to the core acknowledges its breakpoint
      bp_clr[i]       = wr_req_i[i].we & ~wr_req_i[i].data;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Sticky breakpoint flags
  ////////////////////////////////////////////////////////////////////

  // Set wins over clear, matching the stall register, so a RESUME that
  // overlaps a breakpoint still in flight leaves the flag up
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      bp_seen <= '0;
    end else begin
      bp_seen <= bp_set | (bp_seen & ~bp_clr);
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Readback register
  ////////////////////////////////////////////////////////////////////

  // One more stage gives the host a stable word, a command shows up
  // here three TCK edges after it was issued
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      host_status_o <= '0;
    end else begin
      host_status_o.stalled <= stalled_mask;
      host_status_o.bp_seen <= bp_seen;
    end
  end

endmodule

// File: design/dbg_stall_cell.sv
// Per-core stall cell
// Sticky breakpoint latch in the CPU domain, host stall register in the TCK
// domain, and a two-flop synchronizer in each direction between them

`timescale 1ns/1ps

module dbg_stall_cell
  import dbg_pkg::*;
(
  input  logic         tck_i,
  input  logic         tlr_i,
  input  logic         cpu_clk_i,
  input  logic         cpu_rstn_i,
  input  stall_wr_t    wr_req_i,
  input  logic         bp_i,
  output logic         cpu_stall_o,
  output core_status_t status_o
);

  // Breakpoint latch and its two stages into TCK
  logic stall_bp;
  logic stall_bp_csff;
  logic stall_bp_tck;

  // Host stall register and its two stages into the CPU clock
  logic stall_reg;
  logic stall_reg_csff;
  logic stall_reg_cpu;

  ////////////////////////////////////////////////////////////////////
  // CPU domain breakpoint latch
  ////////////////////////////////////////////////////////////////////

  // A breakpoint sets the latch and only the host can release it.
  // The latch drops once the host register, seen back in the CPU domain,
  // has taken over the stall, so the core never slips out in between
  always_ff @(posedge cpu_clk_i or negedge cpu_rstn_i) begin
    if (!cpu_rstn_i) begin
      stall_bp <= 1'b0;
    end else if (bp_i) begin
      stall_bp <= 1'b1;
    end else if (stall_reg_cpu) begin
      stall_bp <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Crossing into TCK
  ////////////////////////////////////////////////////////////////////

  // TCK can be slow and irregular, so the latch holds the level
  // long enough for this pair to pick it up
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      stall_bp_csff <= 1'b0;
      stall_bp_tck  <= 1'b0;
    end else begin
      stall_bp_csff <= stall_bp;
      stall_bp_tck  <= stall_bp_csff;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // TCK domain host stall register
  ////////////////////////////////////////////////////////////////////

  // A synchronized breakpoint forces the stall on and beats any write.
  // Otherwise the decoder's request sets or clears it
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      stall_reg <= 1'b0;
    end else if (stall_bp_tck) begin
      stall_reg <= 1'b1;
    end else if (wr_req_i.we) begin
      stall_reg <= wr_req_i.data;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Crossing back into the CPU clock
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge cpu_clk_i or negedge cpu_rstn_i) begin
    if (!cpu_rstn_i) begin
      stall_reg_csff <= 1'b0;
      stall_reg_cpu  <= 1'b0;
    end else begin
      stall_reg_csff <= stall_reg;
      stall_reg_cpu  <= stall_reg_csff;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////

  // The raw breakpoint stalls the core in the same cycle, the latch
  // covers the crossing and the host register keeps it stalled after
  assign cpu_stall_o = bp_i | stall_bp | stall_reg_cpu;

  // Both status bits are TCK-domain flops
  assign status_o.stalled = stall_reg;
  assign status_o.bp_tck  = stall_bp_tck;

endmodule

// File: design/dbg_cmd_decode.sv
// Host command decoder
// Turns one TCK-domain host command into a registered write request for
// every core, so the cells never see the command encoding

`timescale 1ns/1ps

`include "dbg_stall_config.svh"

module dbg_cmd_decode
  import dbg_pkg::*;
(
  input  logic                                tck_i,
  input  logic                                tlr_i,
  input  dbg_cmd_e                            host_cmd_i,
  input  core_mask_t                          host_mask_i,
  output stall_wr_t [`DBG_NUM_CORES-1:0]      wr_req_o
);

  ////////////////////////////////////////////////////////////////////
  // Combinational decode
  ////////////////////////////////////////////////////////////////////

  // Next-cycle write enables and data, one bit per core
  core_mask_t we_d;
  core_mask_t data_d;

  always_comb begin
    we_d   = '0;
    data_d = '0;
    case (host_cmd_i)
      // Every core is written, the mask itself is the new stall pattern
      CMD_WRITE: begin
        we_d   = '1;
        data_d = host_mask_i;
      end
      // Only masked cores are written, and they get a stall
      CMD_HALT: begin
        we_d   = host_mask_i;
        data_d = '1;
      end
      // Only masked cores are written, and they are released
      CMD_RESUME: begin
        we_d   = host_mask_i;
        data_d = '0;
      end
      default: begin
        we_d   = '0;
        data_d = '0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // Request registers
  ////////////////////////////////////////////////////////////////////

  // Each request holds for exactly one TCK cycle after the command edge
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      wr_req_o <= '0;
    end else begin
      for (int i = 0; i < `DBG_NUM_CORES; i++) begin
        wr_req_o[i].we   <= we_d[i];
        wr_req_o[i].data <= data_d[i];
      end
    end
  end

endmodule

// File: design/dbg_pkg.sv
// Debug stall controller types
// Core masks, host command encoding and the per-core request and status records

`include "dbg_stall_config.svh"

package dbg_pkg;

  ////////////////////////////////////////////////////////////////////
  // Core masks
  ////////////////////////////////////////////////////////////////////

  // One bit per core, indexed by the flat core number
  typedef logic [`DBG_NUM_CORES-1:0] core_mask_t;

  ////////////////////////////////////////////////////////////////////
  // Host command
  ////////////////////////////////////////////////////////////////////

  // CMD_NOP is the idle value the host drives between commands
  typedef enum logic [1:0] {
    CMD_NOP    = 2'd0,
    CMD_WRITE  = 2'd1,
    CMD_HALT   = 2'd2,
    CMD_RESUME = 2'd3
  } dbg_cmd_e;

  // Write request to a single core's host stall register
  typedef struct packed {
    logic we;
    logic data;
  } stall_wr_t;

  // What one stall cell reports back in the TCK domain
  typedef struct packed {
    logic stalled;
    logic bp_tck;
  } core_status_t;

  // Host readback word, stall state on top and sticky breakpoint flags below
  typedef struct packed {
    core_mask_t stalled;
    core_mask_t bp_seen;
  } status_word_t;

endpackage

// File: design/dbg_stall_config.svh
// Debug stall controller configuration
// Geometry of the tile array and the flat core count derived from it

`ifndef DBG_STALL_CONFIG_SVH
`define DBG_STALL_CONFIG_SVH

// Tile array dimensions
`define DBG_X              2
`define DBG_Y              2
`define DBG_Z              1

// Cores inside one tile
`define DBG_CORES_PER_TILE 1

// Total cores in the array
// Flat index is ((x * Y + y) * Z + z) * CORES_PER_TILE + t, so the core
// number within a tile runs fastest and the X coordinate slowest
`define DBG_NUM_CORES ((`DBG_X) * (`DBG_Y) * (`DBG_Z) * (`DBG_CORES_PER_TILE))

`endif
